// File: Bender.yml
package:
  name: adc_link

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/adc_link_pkg.sv
      - src/tx_link_if.sv
      - src/sample_sequencer.sv
      - src/frame_handshake.sv
      - src/tx_buffer.sv
      - src/serial_tx.sv
      - src/adc_link_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - test/adc_link_sva.sv
      - test/adc_link_checker.sv
      - test/adc_link_tb.sv

// File: build.f
+incdir+src
src/adc_link_pkg.sv
src/tx_link_if.sv
src/sample_sequencer.sv
src/frame_handshake.sv
src/tx_buffer.sv
src/serial_tx.sv
src/adc_link_top.sv
test/adc_link_sva.sv
test/adc_link_checker.sv
test/adc_link_tb.sv

// File: src/adc_link_params.svh
// adc link parameters
`ifndef ADC_LINK_PARAMS_SVH
`define ADC_LINK_PARAMS_SVH

// multiplexer inputs
`define ADC_LINK_CHANNELS 8

// clock cycles per serial bit
`define ADC_LINK_BIT_PERIOD 104

// bit timer width, must hold bit period minus one
`define ADC_LINK_TIMER_W 10

`endif

// File: src/adc_link_pkg.sv
// adc link shared types
`default_nettype none

package adc_link_pkg;

	// one converter byte
	typedef logic [7:0] sample_t;

	// mux address, bit 3 stays zero with eight inputs
	typedef logic [3:0] channel_t;

	// frame position, 0 is start, 1 to 8 data, 9 stop
	typedef logic [3:0] bit_count_t;

	// per-sample control flow of the sequencer
	typedef enum logic [2:0] {
		seq_mux_on,
		seq_mux_settle,
		seq_convert,
		seq_wait_eoc,
		seq_fetch,
		seq_step_channel,
		seq_request,
		seq_wait_ready
	} seq_state_t;

	// one pass per serial frame
	typedef enum logic [1:0] {
		lnk_idle,
		lnk_load,
		lnk_send,
		lnk_wait_end
	} link_state_t;

endpackage

`default_nettype wire

// File: src/adc_link_top.sv
// adc sampling link top
`timescale 1ns/1ps
`default_nettype none
`include "adc_link_params.svh"

module adc_link_top #(
	parameter int bit_period = `ADC_LINK_BIT_PERIOD
) (
	input  logic                   clock,
	input  logic                   rst,
	input  logic                   eoc,
	input  adc_link_pkg::sample_t  data_in,
	input  logic                   dsr,
	output logic                   soc,
	output logic                   load_sample,
	output logic                   high_byte_sel,
	output adc_link_pkg::channel_t channel,
	output logic                   mux_en,
	output logic                   error,
	output logic                   data_out
);

	// sequencer request and handshake answer
	logic send_data;
	logic rdy;

	tx_link_if link ();

	sample_sequencer u_sequencer (
		.clock       (clock),
		.rst         (rst),
		.eoc         (eoc),
		.rdy         (rdy),
		.mux_en      (mux_en),
		.soc         (soc),
		.load_sample (load_sample),
		.send_data   (send_data),
		.channel     (channel)
	);

	frame_handshake u_handshake (
		.clock         (clock),
		.rst           (rst),
		.send_data     (send_data),
		.rdy           (rdy),
		.high_byte_sel (high_byte_sel),
		.link          (link.handshake)
	);

	// data_in is already the byte picked by high_byte_sel
	tx_buffer u_buffer (
		.clock   (clock),
		.rst     (rst),
		.data_in (data_in),
		.dsr     (dsr),
		.error   (error),
		.link    (link.buffer)
	);

	serial_tx #(
		.bit_period (bit_period)
	) u_serial (
		.clock    (clock),
		.rst      (rst),
		.data_out (data_out),
		.link     (link.serializer)
	);

endmodule

`default_nettype wire

// File: src/frame_handshake.sv
// two-frame handshake
`timescale 1ns/1ps
`default_nettype none

module frame_handshake (
	input  logic clock,
	input  logic rst,
	input  logic send_data,
	output logic rdy,
	output logic high_byte_sel,
	tx_link_if.handshake link
);
	import adc_link_pkg::*;

	link_state_t state;

	// strobes decode straight from the state
	assign link.load = (state == lnk_load);
	assign link.send = (state == lnk_send);

	always_ff @(posedge clock) begin
		if (rst) begin
			state         <= lnk_idle;
			rdy           <= 1'b0;
			high_byte_sel <= 1'b0;
		end else begin
			case (state)
				lnk_idle: begin
					// accept a sample, low byte goes first
					if (send_data) begin
						rdy   <= 1'b1;
						state <= lnk_load;
					end
				end
				lnk_load: begin
					// buffer takes data_in this cycle
					state <= lnk_send;
				end
				lnk_send: begin
					state <= lnk_wait_end;
				end
				lnk_wait_end: begin
					// tx_end confirms the frame on the line
					if (link.tx_end) begin
						if (!high_byte_sel) begin
							// low byte done, go again for the high byte
							high_byte_sel <= 1'b1;
							state         <= lnk_load;
						end else begin
							// both bytes out, select cleared every sample
							high_byte_sel <= 1'b0;
							rdy           <= 1'b0;
							state         <= lnk_idle;
						end
					end
				end
				default: begin
					state <= lnk_idle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: src/sample_sequencer.sv
// sample control sequencer
`timescale 1ns/1ps
`default_nettype none
`include "adc_link_params.svh"

module sample_sequencer (
	input  logic                  clock,
	input  logic                  rst,
	input  logic                  eoc,
	input  logic                  rdy,
	output logic                  mux_en,
	output logic                  soc,
	output logic                  load_sample,
	output logic                  send_data,
	output adc_link_pkg::channel_t channel
);
	import adc_link_pkg::*;

	// highest channel before wrapping back to 0
	localparam channel_t last_channel = channel_t'(`ADC_LINK_CHANNELS - 1);

	seq_state_t state;

	always_ff @(posedge clock) begin
		if (rst) begin
			state       <= seq_mux_on;
			mux_en      <= 1'b0;
			soc         <= 1'b0;
			load_sample <= 1'b0;
			send_data   <= 1'b0;
			channel     <= '0;
		end else begin
			case (state)
				seq_mux_on: begin
					// mux enabled one cycle after reset or a finished sample
					mux_en <= 1'b1;
					state  <= seq_mux_settle;
				end
				seq_mux_settle: begin
					// one idle cycle lets the mux output settle
					state <= seq_convert;
				end
				seq_convert: begin
					soc   <= 1'b1;
					state <= seq_wait_eoc;
				end
				seq_wait_eoc: begin
					// eoc is a level, high once the result is ready
					if (eoc) begin
						load_sample <= 1'b1;
						mux_en      <= 1'b0;
						state       <= seq_fetch;
					end
				end
				seq_fetch: begin
					// result presented for one cycle, then conversion ends
					load_sample <= 1'b0;
					soc         <= 1'b0;
					// next channel shows up as soc drops
					if (channel == last_channel) begin
						channel <= '0;
					end else begin
						channel <= channel + channel_t'(1);
					end
					state <= seq_step_channel;
				end
				seq_step_channel: begin
					send_data <= 1'b1;
					state     <= seq_request;
				end
				seq_request: begin
					// request stays up until the handshake answers with rdy
					if (rdy) begin
						send_data <= 1'b0;
						state     <= seq_wait_ready;
					end
				end
				seq_wait_ready: begin
					// rdy falls once both bytes went out
					if (!rdy) begin
						state <= seq_mux_on;
					end
				end
				default: begin
					state <= seq_mux_on;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: src/serial_tx.sv
// serial frame transmitter
`timescale 1ns/1ps
`default_nettype none
`include "adc_link_params.svh"

module serial_tx #(
	parameter int bit_period = `ADC_LINK_BIT_PERIOD
) (
	input  logic clock,
	input  logic rst,
	output logic data_out,
	tx_link_if.serializer link
);
	import adc_link_pkg::*;

	localparam int timer_w = `ADC_LINK_TIMER_W;
	// timer value in the last cycle of a bit
	localparam logic [timer_w-1:0] last_tick = timer_w'(bit_period - 1);
	// start is 0, data 1 to 8, stop 9
	localparam bit_count_t stop_pos = bit_count_t'(9);

	logic [timer_w-1:0] timer;
	bit_count_t         pos;
	logic               bit_done;
	logic [2:0]         data_idx;

	assign bit_done = (timer == last_tick);

	// position 1 carries bit 7, position 8 bit 0
	assign data_idx = 3'(bit_count_t'(8) - pos);

	always_ff @(posedge clock) begin
		if (rst) begin
			timer <= '0;
			pos   <= '0;
		end else if (!link.send_en) begin
			// idle, next frame starts at the start bit
			timer <= '0;
			pos   <= '0;
		end else if (bit_done) begin
			timer <= '0;
			if (pos == stop_pos) begin
				pos <= '0;
			end else begin
				pos <= pos + bit_count_t'(1);
			end
		end else begin
			timer <= timer + 1'b1;
		end
	end

	// pulse in the final cycle of stop, buffer drops send_en on it
	assign link.tx_end = link.send_en && bit_done && (pos == stop_pos);

	// line bit, high while idle
	always_comb begin
		if (!link.send_en) begin
			data_out = 1'b1;
		end else if (pos == '0) begin
			data_out = 1'b0;
		end else if (pos == stop_pos) begin
			data_out = 1'b1;
		end else begin
			data_out = link.frame[data_idx];
		end
	end

endmodule

`default_nettype wire

// File: src/tx_buffer.sv
// transmit frame buffer
`timescale 1ns/1ps
`default_nettype none

module tx_buffer (
	input  logic                  clock,
	input  logic                  rst,
	input  adc_link_pkg::sample_t data_in,
	input  logic                  dsr,
	output logic                  error,
	tx_link_if.buffer             link
);

	// a byte is loaded and not yet sent
	logic full;

	// payload only, follows load
	always_ff @(posedge clock) begin
		if (link.load) begin
			link.frame <= data_in;
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			full         <= 1'b0;
			link.send_en <= 1'b0;
			error        <= 1'b0;
		end else begin
			if (link.load) begin
				full <= 1'b1;
			end
			if (link.tx_end) begin
				// frame is out, buffer free again
				link.send_en <= 1'b0;
				full         <= 1'b0;
			end else if ((link.send && full) || error) begin
				// error doubles as the pending flag, dsr checked each cycle
				if (dsr) begin
					link.send_en <= 1'b1;
					error        <= 1'b0;
				end else begin
					error <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: src/tx_link_if.sv
// transmit link interface
`timescale 1ns/1ps
`default_nettype none

interface tx_link_if;
	import adc_link_pkg::*;

	// handshake strobes, one cycle each
	logic    load;
	logic    send;
	// byte held for the serializer
	sample_t frame;
	// serializer runs while this is high
	logic    send_en;
	// last cycle of the stop bit
	logic    tx_end;

	modport handshake (output load, output send, input tx_end);

	modport buffer (input load, input send, input tx_end, output frame, output send_en);

	modport serializer (input frame, input send_en, output tx_end);

endinterface

`default_nettype wire

// File: test/adc_link_checker.sv
// link output checker
`timescale 1ns/1ps
`default_nettype none
`include "adc_link_params.svh"

module adc_link_checker #(
	parameter int bit_period = 8
) (
	input  logic                   clock,
	input  logic                   rst,
	input  logic                   soc,
	input  logic                   eoc,
	input  logic                   load_sample,
	input  logic                   high_byte_sel,
	input  adc_link_pkg::channel_t channel,
	input  logic                   mux_en,
	input  logic                   error,
	input  logic                   data_out,
	input  logic                   dsr,
	// converter model pushes once per conversion
	input  logic                   exp_push,
	input  adc_link_pkg::sample_t  exp_lo,
	input  adc_link_pkg::sample_t  exp_hi,
	output int                     checks,
	output int                     errors,
	output int                     samples_done
);
	import adc_link_pkg::*;

	localparam int frame_len = 10 * bit_period;

	// {high, low} per pending sample
	logic [15:0] expected_q[$];
	channel_t    exp_channel;
	logic        reset_done;
	logic        soc_q;
	// dsr as the buffer saw it on the last edge
	logic        dsr_q;
	logic        eoc_seen;
	int          loads;
	logic        in_frame;
	int          bit_pos;
	logic        bit_level;
	logic        frame_sel;
	logic [9:0]  frame_bits;
	int          frames_seen;
	int          err_mark;

	task automatic flag_failure(input string what);
		errors = errors + 1;
		$display("** Error at %0t ns: %s", $time, what);
	endtask

	task automatic expect_true(input logic ok, input string what);
		checks = checks + 1;
		if (!ok) begin
			flag_failure(what);
		end
	endtask

	// frame_bits holds start, data msb first, stop
	task automatic close_frame();
		sample_t want;
		expect_true(!frame_bits[9] && frame_bits[0], "bad start or stop bit");
		if (expected_q.size() == 0) begin
			flag_failure("frame sent with no conversion behind it");
		end else begin
			want = (frames_seen == 0) ? expected_q[0][7:0] : expected_q[0][15:8];
			expect_true(frame_sel == (frames_seen == 1), "high_byte_sel wrong for this frame");
			expect_true(frame_bits[8:1] == want,
				$sformatf("frame byte %h, expected %h", frame_bits[8:1], want));
			frames_seen = frames_seen + 1;
			if (frames_seen == 2) begin
				$display("sample %0d on channel %0d: lo %h hi %h, %s", samples_done,
					samples_done % `ADC_LINK_CHANNELS, expected_q[0][7:0],
					expected_q[0][15:8], (errors == err_mark) ? "ok" : "mismatch");
				void'(expected_q.pop_front());
				frames_seen  = 0;
				samples_done = samples_done + 1;
				err_mark     = errors;
			end
		end
	endtask

	always @(posedge clock) begin
		if (rst) begin
			expected_q.delete();
			exp_channel  = '0;
			reset_done   = 1'b0;
			soc_q        = 1'b0;
			dsr_q        = 1'b1;
			in_frame     = 1'b0;
			frames_seen  = 0;
			checks       = 0;
			errors       = 0;
			samples_done = 0;
			err_mark     = 0;
		end else begin
			// first edge out of reset still shows the reset values
			if (!reset_done) begin
				expect_true(!mux_en && !soc && !load_sample, "mux_en, soc or load_sample set");
				expect_true(!high_byte_sel && !error, "high_byte_sel or error set after reset");
				expect_true(channel == '0, "channel not 0 after reset");
				expect_true(data_out, "line not idle high after reset");
				$display("reset state: %s", (errors == 0) ? "ok" : "mismatch");
				err_mark   = errors;
				reset_done = 1'b1;
			end
			if (exp_push) begin
				expected_q.push_back({exp_hi, exp_lo});
			end
			if (channel[3]) begin
				flag_failure("channel bit 3 set");
			end
			// new conversion
			if (soc && !soc_q) begin
				expect_true(channel == exp_channel,
					$sformatf("channel %0d at soc, expected %0d", channel, exp_channel));
				// mux comes up two cycles ahead of soc
				expect_true(mux_en, "mux_en low when soc rose");
				expect_true(frames_seen == 0, "previous sample did not send two frames");
				exp_channel = channel_t'((int'(exp_channel) + 1) % `ADC_LINK_CHANNELS);
				loads       = 0;
				eoc_seen    = 1'b0;
			end
			if (soc && eoc) begin
				eoc_seen = 1'b1;
			end
			if (load_sample) begin
				loads = loads + 1;
				if (!eoc_seen) begin
					flag_failure("load_sample before eoc was high");
				end
				// mux released in the same cycle the result is fetched
				expect_true(!mux_en, "mux_en still high during load_sample");
			end
			if (!soc && soc_q) begin
				expect_true(eoc_seen, "soc fell before eoc was high");
				expect_true(loads == 1, $sformatf("%0d load_sample pulses in one conversion", loads));
			end
			// error only while a frame is held back by dsr
			if (error && (dsr_q || in_frame)) begin
				flag_failure("error high without a frame waiting on dsr");
			end
			if (!in_frame && !data_out) begin
				expect_true(dsr_q, "start bit began while dsr was low");
				in_frame  = 1'b1;
				bit_pos   = 0;
				frame_sel = high_byte_sel;
			end
			if (in_frame) begin
				// every bit holds its level for the whole period
				if (bit_pos % bit_period == 0) begin
					bit_level = data_out;
				end else if (data_out != bit_level) begin
					flag_failure($sformatf("line changed inside bit %0d", bit_pos / bit_period));
				end
				// mid-bit sample
				if (bit_pos % bit_period == bit_period / 2) begin
					frame_bits = {frame_bits[8:0], data_out};
				end
				bit_pos = bit_pos + 1;
				if (bit_pos == frame_len) begin
					in_frame = 1'b0;
					close_frame();
				end
			end
			soc_q = soc;
			dsr_q = dsr;
		end
	end

endmodule

`default_nettype wire

// File: test/adc_link_sva.sv
// link protocol assertions
`timescale 1ns/1ps
`default_nettype none

module adc_link_sva (
	input logic clock,
	input logic rst,
	input logic load,
	input logic send,
	input logic tx_end,
	input logic error,
	input logic send_en,
	input logic rdy,
	input logic high_byte_sel
);

	// read by the testbench summary
	int failures = 0;

	// strobes decode from two different handshake states
	assert property (@(posedge clock) disable iff (rst) !(load && send))
		else begin
			$error("load and send high in the same cycle");
			failures++;
		end

	// a refused frame is never on the line
	assert property (@(posedge clock) disable iff (rst) !(error && tx_end))
		else begin
			$error("error and tx_end high in the same cycle");
			failures++;
		end

	assert property (@(posedge clock) disable iff (rst) !(send_en && error))
		else begin
			$error("send_en high while error is high");
			failures++;
		end

	// high byte select only inside an accepted sample
	assert property (@(posedge clock) disable iff (rst) high_byte_sel |-> rdy)
		else begin
			$error("high_byte_sel high while rdy is low");
			failures++;
		end

endmodule

// handshake has no error or send_en, tied to their idle level
bind frame_handshake adc_link_sva u_sva (
	.clock (clock), .rst (rst), .load (link.load), .send (link.send),
	.tx_end (link.tx_end), .error (1'b0), .send_en (1'b0),
	.rdy (rdy), .high_byte_sel (high_byte_sel)
);

// buffer cannot see rdy or the byte select
bind tx_buffer adc_link_sva u_sva (
	.clock (clock), .rst (rst), .load (link.load), .send (link.send),
	.tx_end (link.tx_end), .error (error), .send_en (link.send_en),
	.rdy (1'b0), .high_byte_sel (1'b0)
);

`default_nettype wire

// File: test/adc_link_tb.sv
// adc link testbench
`timescale 1ns/1ps
`default_nettype none

module adc_link_tb;
	import adc_link_pkg::*;

	localparam int clock_period = 10;
	localparam int bit_period   = 8;
	localparam int samples      = 24;
	localparam int frame_cycles = 10 * bit_period;
	localparam int max_dsr_low  = 40;
	// one dsr window per frame plus conversion and control steps per sample
	localparam int slack_cycles = samples * 2 * max_dsr_low + samples * 30;
	localparam int limit_cycles = 2 * (samples * 2 * frame_cycles + slack_cycles);
	localparam logic [31:0] seed = 32'h5750_e813;

	logic         clock = 1'b0;
	logic         rst;
	logic         eoc;
	logic         dsr;
	sample_t      data_in;
	logic         soc;
	logic         load_sample;
	logic         high_byte_sel;
	channel_t     channel;
	logic         mux_en;
	logic         error;
	logic         data_out;
	// converter model state
	sample_t      lo_byte;
	sample_t      hi_byte;
	logic         exp_push;
	logic [31:0]  conv_rng;
	logic [31:0]  dsr_rng;
	int           checks;
	int           errors;
	int           samples_done;
	int           sva_failures;

	always #(clock_period / 2) clock = ~clock;

	function automatic logic [31:0] next_random(input logic [31:0] state);
		logic [31:0] x;
		x = state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// converter output mux follows the byte select
	assign data_in = high_byte_sel ? hi_byte : lo_byte;

	adc_link_top #(
		.bit_period (bit_period)
	) UUT (
		.clock         (clock),
		.rst           (rst),
		.eoc           (eoc),
		.data_in       (data_in),
		.dsr           (dsr),
		.soc           (soc),
		.load_sample   (load_sample),
		.high_byte_sel (high_byte_sel),
		.channel       (channel),
		.mux_en        (mux_en),
		.error         (error),
		.data_out      (data_out)
	);

	adc_link_checker #(
		.bit_period (bit_period)
	) u_checker (
		.clock         (clock),
		.rst           (rst),
		.soc           (soc),
		.eoc           (eoc),
		.load_sample   (load_sample),
		.high_byte_sel (high_byte_sel),
		.channel       (channel),
		.mux_en        (mux_en),
		.error         (error),
		.data_out      (data_out),
		.dsr           (dsr),
		.exp_push      (exp_push),
		.exp_lo        (lo_byte),
		.exp_hi        (hi_byte),
		.checks        (checks),
		.errors        (errors),
		.samples_done  (samples_done)
	);

	// one conversion, new bytes and a random 1 to 12 cycle delay before eoc
	task automatic run_conversion();
		int delay;
		@(posedge clock);
		while (!soc) @(posedge clock);
		conv_rng = next_random(conv_rng);
		lo_byte  <= conv_rng[7:0];
		hi_byte  <= conv_rng[15:8];
		exp_push <= 1'b1;
		delay = 1 + int'(conv_rng[31:16] % 16'd12);
		@(posedge clock);
		exp_push <= 1'b0;
		repeat (delay - 1) @(posedge clock);
		// eoc is a level, held until soc drops
		eoc <= 1'b1;
		@(posedge clock);
		while (soc) @(posedge clock);
		eoc <= 1'b0;
	endtask

	initial begin
		eoc      = 1'b0;
		lo_byte  = '0;
		hi_byte  = '0;
		exp_push = 1'b0;
		conv_rng = seed;
		wait (rst === 1'b0);
		forever run_conversion();
	end

	// dsr mostly high, low windows of 0 to 40 cycles
	initial begin
		dsr     = 1'b1;
		dsr_rng = ~seed;
		forever begin
			dsr_rng = next_random(dsr_rng);
			repeat (20 + int'(dsr_rng[15:0] % 16'd200)) @(posedge clock);
			dsr <= 1'b0;
			repeat (int'(dsr_rng[31:16] % 16'd41)) @(posedge clock);
			dsr <= 1'b1;
		end
	end

	initial begin
		#(limit_cycles * clock_period);
		$display("watchdog expired after %0d cycles, %0d of %0d samples done",
			limit_cycles, samples_done, samples);
		$display("Simulation FAILED");
		$finish;
	end

	initial begin
		rst = 1'b1;
		repeat (5) @(posedge clock);
		rst <= 1'b0;
		wait (samples_done == samples);
		repeat (4) @(posedge clock);
		sva_failures = UUT.u_handshake.u_sva.failures + UUT.u_buffer.u_sva.failures;
		$display("checks %0d, errors %0d, assertion failures %0d", checks, errors, sva_failures);
		if (errors == 0 && sva_failures == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
